// ==== verilog/nf_pkg.sv ====
package nf_pkg;

    // major opcodes, instruction bits 6..2
    typedef enum logic [4:0] {
        opc_load   = 5'b00000,                  // lw
        opc_op_imm = 5'b00100,                  // addi ori slli srli
        opc_store  = 5'b01000,                  // sw
        opc_op     = 5'b01100,                  // add sub or sll srl
        opc_lui    = 5'b01101,                  // lui
        opc_branch = 5'b11000                   // beq bne
    } opcode_t;

    // alu operations
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_or  = 3'b010,
        alu_sll = 3'b011,
        alu_srl = 3'b100,
        alu_lui = 3'b101                        // pass src_b through
    } alu_code_t;

    // immediate format for the sign extender
    typedef enum logic [1:0] {
        imm_i = 2'b00,
        imm_s = 2'b01,
        imm_b = 2'b10,
        imm_u = 2'b11
    } imm_src_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
        logic [1:0] instr_type;                 // 2'b11 for 32-bit encodings
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;                     // low 5 bits double as shamt
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
        logic [1:0]  instr_type;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo5;
        opcode_t    opcode;
        logic [1:0] instr_type;
    } instr_s_t;

    typedef struct packed {
        logic       b12;                        // sign bit of the offset
        logic [5:0] imm_hi6;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_lo4;
        logic       b11;
        opcode_t    opcode;
        logic [1:0] instr_type;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm20;                     // upper immediate
        logic [4:0]  rd;
        opcode_t     opcode;
        logic [1:0]  instr_type;
    } instr_u_t;

    // one 32-bit word, five format views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
    } instr_u;

    // decoded control bundle
    typedef struct packed {
        alu_code_t alu_code;
        logic      src_b_sel;                   // immediate as alu operand b
        logic      we_rf;                       // register file write
        logic      we_dm;                       // data memory write
        logic      rf_src;                      // writeback from memory
        logic      branch_type;                 // beq or bne
        logic      eq_neq;                      // 1 for bne
    } ctrl_t;

endpackage : nf_pkg

// ==== verilog/nf_sign_ex.sv ====
`timescale 1ns/1ns

module nf_sign_ex (
    input  logic [11:0]      imm_data_i,        // i-type immediate
    input  logic [11:0]      imm_data_s,        // s-type immediate
    input  logic [11:0]      imm_data_b,        // b-type offset without bit 0
    input  logic [19:0]      imm_data_u,        // u-type upper immediate
    input  nf_pkg::imm_src_t imm_src,           // which format
    output logic [31:0]      imm_ex             // 32-bit result
);

    import nf_pkg::*;

    always_comb begin
        case (imm_src)
            imm_i:   imm_ex = {{20{imm_data_i[11]}}, imm_data_i};
            imm_s:   imm_ex = {{20{imm_data_s[11]}}, imm_data_s};
            imm_b:   imm_ex = {{19{imm_data_b[11]}}, imm_data_b, 1'b0};   // halfword offset
            imm_u:   imm_ex = {imm_data_u, 12'b0};
            default: imm_ex = '0;
        endcase
    end

endmodule : nf_sign_ex

// ==== verilog/nf_control_unit.sv ====
`timescale 1ns/1ns

module nf_control_unit (
    input  logic [1:0]        instr_type,       // low two bits of the word
    input  nf_pkg::opcode_t   opcode,           // major opcode
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    output nf_pkg::ctrl_t     ctrl,             // control bundle
    output nf_pkg::imm_src_t  imm_src           // immediate format
);

    import nf_pkg::*;

    always_comb begin
        ctrl          = '0;                     // no-op unless decoded below
        ctrl.alu_code = alu_add;
        imm_src       = imm_i;
        if (instr_type == 2'b11) begin
            case (opcode)
                opc_lui: begin
                    ctrl.alu_code  = alu_lui;
                    ctrl.src_b_sel = 1'b1;
                    ctrl.we_rf     = 1'b1;
                    imm_src        = imm_u;
                end
                opc_op_imm: begin
                    ctrl.src_b_sel = 1'b1;
                    imm_src        = imm_i;
                    case (funct3)
                        3'b000: begin
                            ctrl.alu_code = alu_add;    // addi
                            ctrl.we_rf    = 1'b1;
                        end
                        3'b110: begin
                            ctrl.alu_code = alu_or;     // ori
                            ctrl.we_rf    = 1'b1;
                        end
                        3'b001: begin
                            ctrl.alu_code = alu_sll;    // slli
                            ctrl.we_rf    = (funct7 == 7'b0000000);
                        end
                        3'b101: begin
                            ctrl.alu_code = alu_srl;    // srli only, no srai
                            ctrl.we_rf    = (funct7 == 7'b0000000);
                        end
                        default: ctrl.we_rf = 1'b0;
                    endcase
                end
                opc_op: begin
                    case ({funct7, funct3})
                        10'b0000000_000: ctrl.alu_code = alu_add;
                        10'b0100000_000: ctrl.alu_code = alu_sub;
                        10'b0000000_110: ctrl.alu_code = alu_or;
                        10'b0000000_001: ctrl.alu_code = alu_sll;
                        10'b0000000_101: ctrl.alu_code = alu_srl;
                        default:         ctrl.alu_code = alu_add;
                    endcase
                    ctrl.we_rf = ({funct7, funct3} inside {10'b0000000_000,
                                                            10'b0100000_000,
                                                            10'b0000000_110,
                                                            10'b0000000_001,
                                                            10'b0000000_101});
                end
                opc_branch: begin
                    imm_src          = imm_b;
                    ctrl.branch_type = (funct3 == 3'b000) | (funct3 == 3'b001);
                    ctrl.eq_neq      = (funct3 == 3'b001);   // bne
                end
                opc_load: begin
                    ctrl.src_b_sel = 1'b1;      // rs1 + offset
                    ctrl.we_rf     = (funct3 == 3'b010);     // lw only
                    ctrl.rf_src    = 1'b1;
                    imm_src        = imm_i;
                end
                opc_store: begin
                    ctrl.src_b_sel = 1'b1;
                    ctrl.we_dm     = (funct3 == 3'b010);     // sw only
                    imm_src        = imm_s;
                end
                default: ctrl.alu_code = alu_add;           // unknown opcode
            endcase
        end
    end

endmodule : nf_control_unit

// ==== verilog/nf_i_du.sv ====
`timescale 1ns/1ns

module nf_i_du (
    input  nf_pkg::instr_u instr,               // instruction word at pc
    input  logic [31:0]    rd1,                 // register file read data 1
    input  logic [31:0]    rd2,                 // register file read data 2
    output logic [31:0]    ext_data,            // extended immediate
    output logic [4:0]     shamt,               // immediate shift amount
    output logic [4:0]     ra1,                 // read address 1
    output logic [4:0]     ra2,                 // read address 2
    output logic [4:0]     wa3,                 // write address
    output nf_pkg::ctrl_t  ctrl,                // decoded control
    output logic           pc_src               // take branch target
);

    import nf_pkg::*;

    logic [11:0] imm_data_i;                    // i-type fragment
    logic [11:0] imm_data_s;                    // s-type fragment
    logic [11:0] imm_data_b;                    // b-type fragment, bit 0 implied
    logic [19:0] imm_data_u;                    // u-type fragment
    logic [1:0]  instr_type;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    imm_src_t    imm_src;                       // format chosen by control unit

    // register fields sit at the same place in every format
    assign ra1   = instr.r.rs1;
    assign ra2   = instr.r.rs2;
    assign wa3   = instr.r.rd;
    assign shamt = instr.i.imm12[4:0];

    assign instr_type = instr.r.instr_type;
    assign opcode     = instr.r.opcode;
    assign funct3     = instr.r.funct3;
    assign funct7     = instr.r.funct7;

    assign imm_data_i = instr.i.imm12;
    assign imm_data_s = {instr.s.imm_hi7, instr.s.imm_lo5};
    assign imm_data_b = {instr.b.b12, instr.b.b11, instr.b.imm_hi6, instr.b.imm_lo4};
    assign imm_data_u = instr.u.imm20;

    nf_control_unit nf_control_unit_0 (
        .instr_type ( instr_type ),
        .opcode     ( opcode     ),
        .funct3     ( funct3     ),
        .funct7     ( funct7     ),
        .ctrl       ( ctrl       ),
        .imm_src    ( imm_src    )
    );

    nf_sign_ex nf_sign_ex_0 (
        .imm_data_i ( imm_data_i ),
        .imm_data_s ( imm_data_s ),
        .imm_data_b ( imm_data_b ),
        .imm_data_u ( imm_data_u ),
        .imm_src    ( imm_src    ),
        .imm_ex     ( ext_data   )
    );

    // branch decision: equality, flipped for bne
    assign pc_src = ctrl.branch_type & ((rd1 == rd2) ^ ctrl.eq_neq);

endmodule : nf_i_du

// ==== verilog/nf_reg_file.sv ====
`timescale 1ns/1ns

module nf_reg_file (
    input  logic        clk,
    input  logic        rst_n,                  // blocks writes while low
    input  logic [4:0]  ra1,                    // read address 1
    input  logic [4:0]  ra2,                    // read address 2
    input  logic [4:0]  wa3,                    // write address
    input  logic        we3,                    // write enable
    input  logic [31:0] wd3,                    // write data
    output logic [31:0] rd1,                    // read data 1
    output logic [31:0] rd2                     // read data 2
);

    logic [31:0] regs [32];                     // x0 entry never written

    always_ff @(posedge clk) begin
        if (rst_n && we3 && (wa3 != 5'd0)) begin
            regs[wa3] <= wd3;
        end
    end

    // asynchronous reads, x0 hardwired to zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule : nf_reg_file

// ==== verilog/nf_alu.sv ====
`timescale 1ns/1ns

module nf_alu (
    input  logic [31:0]       src_a,            // rs1 value
    input  logic [31:0]       src_b,            // rs2 value or immediate
    input  logic [4:0]        shamt,            // shift amount
    input  nf_pkg::alu_code_t alu_code,         // operation
    output logic [31:0]       result
);

    import nf_pkg::*;

    always_comb begin
        case (alu_code)
            alu_add: result = src_a + src_b;
            alu_sub: result = src_a - src_b;
            alu_or:  result = src_a | src_b;
            alu_sll: result = src_a << shamt;
            alu_srl: result = src_a >> shamt;   // logical, zero fill
            alu_lui: result = src_b;
            default: result = src_a + src_b;
        endcase
    end

endmodule : nf_alu

// ==== verilog/nf_cpu.sv ====
`timescale 1ns/1ns

module nf_cpu #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000    // first fetch address
) (
    input  logic           clk,
    input  logic           rst_n,
    input  nf_pkg::instr_u instr,               // word at pc, same cycle
    input  logic [31:0]    dm_rd,               // data memory read data
    output logic [31:0]    pc,                  // instruction address
    output logic [31:0]    dm_addr,             // data memory address
    output logic [31:0]    dm_wd,               // data memory write data
    output logic           dm_we                // data memory write strobe
);

    import nf_pkg::*;

    ctrl_t       ctrl;                          // decoded control
    logic [31:0] ext_data;                      // immediate
    logic [4:0]  shamt;                         // immediate shift amount
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  wa3;
    logic        pc_src;                        // branch taken
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] src_b;                         // alu operand b
    logic [4:0]  shift_amt;                     // shamt for slli/srli, rs2 low bits otherwise
    logic [31:0] alu_result;
    logic [31:0] wd3;                           // writeback value
    logic [31:0] pc_next;

    nf_i_du nf_i_du_0 (
        .instr    ( instr    ),
        .rd1      ( rd1      ),
        .rd2      ( rd2      ),
        .ext_data ( ext_data ),
        .shamt    ( shamt    ),
        .ra1      ( ra1      ),
        .ra2      ( ra2      ),
        .wa3      ( wa3      ),
        .ctrl     ( ctrl     ),
        .pc_src   ( pc_src   )
    );

    nf_reg_file nf_reg_file_0 (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .ra1   ( ra1        ),
        .ra2   ( ra2        ),
        .wa3   ( wa3        ),
        .we3   ( ctrl.we_rf ),
        .wd3   ( wd3        ),
        .rd1   ( rd1        ),
        .rd2   ( rd2        )
    );

    assign src_b     = ctrl.src_b_sel ? ext_data : rd2;
    assign shift_amt = ctrl.src_b_sel ? shamt : rd2[4:0];

    nf_alu nf_alu_0 (
        .src_a    ( rd1           ),
        .src_b    ( src_b         ),
        .shamt    ( shift_amt     ),
        .alu_code ( ctrl.alu_code ),
        .result   ( alu_result    )
    );

    assign wd3 = ctrl.rf_src ? dm_rd : alu_result;   // lw or alu result

    assign dm_addr = alu_result;
    assign dm_wd   = rd2;
    assign dm_we   = ctrl.we_dm & rst_n;        // no stores during reset

    // branch target is pc relative
    assign pc_next = pc_src ? (pc + ext_data) : (pc + 32'd4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule : nf_cpu

// ==== testbench/nf_tb_clk.sv ====
`timescale 1ns/1ns

module nf_tb_clk #(
    parameter int PERIOD_NS = 8                 // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                             // first rising edge at half period
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule : nf_tb_clk

// ==== testbench/nf_cpu_chk.sv ====
`timescale 1ns/1ns

module nf_cpu_chk (
    input logic          clk,
    input logic          rst_n,
    input logic [31:0]   pc,                    // fetch address
    input logic          dm_we,                 // data write strobe
    input nf_pkg::ctrl_t ctrl                   // decoded control of current word
);

    int fail_count = 0;                         // read back by the testbench

    // no stores while held in reset
    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dm_we)
        else begin
            fail_count++;
            $error("dm_we high while rst_n is low");
        end

    pc_word_aligned: assert property (@(posedge clk) rst_n |-> (pc[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("pc not word aligned: 0x%08h", pc);
        end

    // straight-line code steps by one word
    pc_plus_four: assert property (@(posedge clk)
        (rst_n && !ctrl.branch_type) |=> (pc == $past(pc) + 32'd4))
        else begin
            fail_count++;
            $error("pc did not advance by 4 after a non-branch");
        end

endmodule : nf_cpu_chk

// ==== testbench/nf_cpu_tb.sv ====
`timescale 1ns/1ns

module nf_cpu_tb;

    import nf_pkg::*;

    localparam logic [31:0] RESET_PC     = 32'h0000_0040;   // nonzero reset address
    localparam int          PROLOGUE     = 32;              // x0 store then one addi per register
    localparam int          RAND_LEN     = 200;
    localparam int          PROG_LEN     = PROLOGUE + RAND_LEN + 1;   // plus parking loop
    localparam int          RESET_CYCLES = 10;
    localparam int          RUN_CYCLES   = PROG_LEN + 10;   // a few turns on the loop
    localparam int          CLK_NS       = 8;
    localparam int          WATCHDOG_NS  = (PROG_LEN + 50) * CLK_NS;

    typedef struct packed {
        logic [31:0] next_pc;
        logic [31:0] addr;                      // expected dm_addr
        logic [31:0] wd;                        // expected dm_wd
        logic        we;                        // expected dm_we
    } step_t;

    logic        clk;
    logic        rst_n;
    instr_u      instr;
    logic [31:0] dm_rd;
    logic [31:0] pc;
    logic [31:0] dm_addr;
    logic [31:0] dm_wd;
    logic        dm_we;

    logic [31:0] imem [PROG_LEN];               // program image starting at RESET_PC
    logic [31:0] dmem [256];                    // memory seen by the DUT
    logic [31:0] ref_regs [32];                 // model state
    logic [31:0] ref_dmem [256];
    logic [31:0] ref_pc;
    integer      seed = 32'ha96f_8fe3;
    int          error_count = 0;
    int          check_count = 0;
    bit          compare_done = 1'b0;

    nf_tb_clk #(.PERIOD_NS(CLK_NS)) clk_gen (.clk(clk));

    nf_cpu #(.RESET_PC(RESET_PC)) DUT (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .instr   ( instr   ),
        .dm_rd   ( dm_rd   ),
        .pc      ( pc      ),
        .dm_addr ( dm_addr ),
        .dm_wd   ( dm_wd   ),
        .dm_we   ( dm_we   )
    );

    bind nf_cpu nf_cpu_chk chk (.clk(clk), .rst_n(rst_n), .pc(pc), .dm_we(dm_we), .ctrl(ctrl));

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr >= RESET_PC && idx < PROG_LEN) begin
            return imem[idx];
        end
        return 32'h0000_0013;                   // addi x0,x0,0 outside the program
    endfunction

    assign instr = fetch_word(pc);              // combinational fetch
    assign dm_rd = dmem[dm_addr[9:2]];          // asynchronous read

    always @(posedge clk) begin
        if (dm_we) begin
            dmem[dm_addr[9:2]] <= dm_wd;
        end
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [31:0] random_instr(input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  sh;
        logic [11:0] imm;
        logic [12:0] off;
        logic [31:0] r;
        int          kind;
        int          k;
        rd   = 5'(rand_below(32));              // x0 allowed as destination
        rs1  = 5'(rand_below(32));
        rs2  = 5'(rand_below(32));
        r    = rand_word();
        imm  = r[11:0];                         // negative half the time
        sh   = (rand_below(4) == 0) ? 5'd31 : 5'(rand_below(32));
        kind = rand_below(15);
        case (kind)
            0:  return {r[31:12], rd, 7'b0110111};                  // lui
            1:  return {imm, rs1, 3'b000, rd, 7'b0010011};          // addi
            2:  return {imm, rs1, 3'b110, rd, 7'b0010011};          // ori
            3:  return {7'b0, sh, rs1, 3'b001, rd, 7'b0010011};     // slli
            4:  return {7'b0, sh, rs1, 3'b101, rd, 7'b0010011};     // srli
            5:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            6:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            7:  return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            8:  return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
            9:  return {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
            10, 11: begin
                k = 1 + rand_below(3);          // short forward hop
                if (idx + k > PROG_LEN - 1) begin
                    k = PROG_LEN - 1 - idx;
                end
                off = 13'(k * 4);
                if (rand_below(2) == 0) begin
                    rs2 = rs1;                  // equal operands now and then
                end
                return {off[12], off[10:5], rs2, rs1, (kind == 11) ? 3'b001 : 3'b000,
                        off[4:1], off[11], 7'b1100011};
            end
            12: begin
                imm = 12'(rand_below(16) * 4);  // small address set so loads hit stores
                return {imm, 5'd0, 3'b010, rd, 7'b0000011};
            end
            13: begin
                imm = 12'(rand_below(16) * 4);
                return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            end
            default: begin
                case (rand_below(3))            // illegal words
                    0:       return {r[31:7], 7'b1110011};
                    1:       return {r[31:2], 2'b00};
                    default: return {7'd0, rs2, 5'd0, 3'b000, 5'd8, 7'b0100011};  // sb
                endcase
            end
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        imem[0] = 32'h0000_2023;                // sw x0,0(x0) sits at pc during reset
        for (int idx = 1; idx < PROLOGUE; idx++) begin
            r = rand_word();
            imem[idx] = {r[11:0], 5'd0, 3'b000, 5'(idx), 7'b0010011};
        end
        for (int idx = PROLOGUE; idx < PROLOGUE + RAND_LEN; idx++) begin
            imem[idx] = random_instr(idx);
        end
        imem[PROG_LEN - 1] = 32'h0000_0063;     // beq x0,x0,0 parks the pc
    endtask

    task automatic fill_memories();
        logic [31:0] v;
        for (int i = 0; i < 256; i++) begin
            v = 32'hc3a5_0f00 ^ (32'(i) * 32'h0101_0101);
            dmem[i]     <= v;
            ref_dmem[i] = v;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
    endtask

    // next state straight from the rv32i encoding rules
    function automatic step_t ref_step(input logic [31:0] cur_pc, input logic [31:0] w);
        step_t       s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] res;
        logic        wr;
        s     = '0;
        s.next_pc = cur_pc + 32'd4;
        wr    = 1'b0;
        res   = 32'd0;
        a     = ref_regs[w[19:15]];
        b     = ref_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[1:0] == 2'b11) begin
            case (w[6:0])
                7'b0110111: begin
                    wr  = 1'b1;
                    res = {w[31:12], 12'd0};
                end
                7'b0010011: begin
                    case (w[14:12])
                        3'b000: {wr, res} = {1'b1, a + imm_i};
                        3'b110: {wr, res} = {1'b1, a | imm_i};
                        3'b001: {wr, res} = {w[31:25] == 7'd0, a << w[24:20]};
                        3'b101: {wr, res} = {w[31:25] == 7'd0, a >> w[24:20]};
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110011: begin
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: {wr, res} = {1'b1, a + b};
                        10'b0100000_000: {wr, res} = {1'b1, a - b};
                        10'b0000000_110: {wr, res} = {1'b1, a | b};
                        10'b0000000_001: {wr, res} = {1'b1, a << b[4:0]};
                        10'b0000000_101: {wr, res} = {1'b1, a >> b[4:0]};
                        default:         wr = 1'b0;
                    endcase
                end
                7'b1100011: begin
                    if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
                        s.next_pc = cur_pc + imm_b;
                    end
                end
                7'b0000011: begin
                    if (w[14:12] == 3'b010) begin
                        wr  = 1'b1;
                        res = ref_dmem[(a + imm_i) >> 2 & 32'hff];
                    end
                end
                7'b0100011: begin
                    if (w[14:12] == 3'b010) begin
                        s.we   = 1'b1;
                        s.addr = a + imm_s;
                        s.wd   = b;
                        ref_dmem[s.addr[9:2]] = b;
                    end
                end
                default: wr = 1'b0;
            endcase
        end
        if (wr && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = res;            // x0 stays zero
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t ns",
                     name, got, expected, $time);
        end
    endtask

    // compare mid-cycle once outputs have settled
    initial begin : compare_proc
        step_t exp;
        int    steps;
        steps  = 0;
        ref_pc = RESET_PC;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                check_value("pc", pc, RESET_PC);
                check_value("dm_we", 32'(dm_we), 32'd0);
            end else if (!compare_done) begin
                exp = ref_step(ref_pc, fetch_word(ref_pc));
                check_value("pc", pc, ref_pc);
                check_value("dm_we", 32'(dm_we), 32'(exp.we));
                if (exp.we) begin
                    check_value("dm_addr", dm_addr, exp.addr);
                    check_value("dm_wd", dm_wd, exp.wd);
                end
                ref_pc = exp.next_pc;
                steps++;
                if (steps == RUN_CYCLES) begin
                    compare_done = 1'b1;
                end
            end
        end
    end

    initial begin : main_seq
        int assert_fails;
        rst_n = 1'b0;
        build_program();
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;                           // released just after an edge
        wait (compare_done);
        @(posedge clk);
        assert_fails = DUT.chk.fail_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : nf_cpu_tb

// ==== flist.f ====
verilog/nf_pkg.sv
verilog/nf_sign_ex.sv
verilog/nf_control_unit.sv
verilog/nf_i_du.sv
verilog/nf_reg_file.sv
verilog/nf_alu.sv
verilog/nf_cpu.sv
testbench/nf_tb_clk.sv
testbench/nf_cpu_chk.sv
testbench/nf_cpu_tb.sv
